//--- tb.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/id_ex_reg.sv
logic/execute_stage.sv
logic/ex_wb_reg.sv
logic/pipe_ctrl.sv
logic/core_top.sv
verification/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module core_tb -f tb.f -o core_sim
./obj_dir/core_sim | tee sim.log
if grep -q "SOME TESTS FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

//--- verification/core_tb.sv
module core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import isa_pkg::*;

	localparam int clk_period    = 40;
	localparam int planned_insts = 141;
	localparam int q_depth       = 512;

	typedef struct packed {
		reg_addr_t addr;
		word_t     data;
		int        cyc;
	} wb_exp_t;

	typedef struct packed {
		word_t pc;
		int    cyc;
	} exc_exp_t;

	logic      clk;
	logic      arst_n;
	logic      inst_valid;
	inst_t     inst;
	word_t     inst_pc;
	logic      fetch_hold;
	logic      wb_en;
	reg_addr_t wb_addr;
	word_t     wb_data;
	logic      exc_valid;
	word_t     exc_pc;

	logic [31:0] lfsr;
	word_t       mregs [32];
	wb_exp_t     wb_q [q_depth];
	exc_exp_t    exc_q [q_depth];
	int          wb_rd = 0;
	int          wb_wr = 0;
	int          exc_rd = 0;
	int          exc_wr = 0;
	int          cyc = 0;
	int          err_cnt = 0;
	int          err_before;
	int          tests_run;
	int          tests_failed;
	int          trap_at;
	logic        mul_pending;
	logic        quiet;
	word_t       pc_next;

	core_top u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst_valid (inst_valid),
		.inst       (inst),
		.inst_pc    (inst_pc),
		.fetch_hold (fetch_hold),
		.wb_en      (wb_en),
		.wb_addr    (wb_addr),
		.wb_data    (wb_data),
		.exc_valid  (exc_valid),
		.exc_pc     (exc_pc)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (arst_n && wb_en) wb_rd <= wb_rd + 1;
		if (arst_n && exc_valid) exc_rd <= exc_rd + 1;
	end

	//////////////////////////////
	// Checks
	//////////////////////////////
	wb_check: assert property (@(posedge clk) disable iff (!arst_n)
		wb_en |-> wb_rd != wb_wr && wb_addr == wb_q[wb_rd].addr
			&& wb_data == wb_q[wb_rd].data && cyc == wb_q[wb_rd].cyc)
	else begin
		err_cnt++;
		$display("mismatch at %0t: r%0d = %h in cycle %0d, expected r%0d = %h in cycle %0d",
			$time, $sampled(wb_addr), $sampled(wb_data), $sampled(cyc),
			wb_q[$sampled(wb_rd)].addr, wb_q[$sampled(wb_rd)].data, wb_q[$sampled(wb_rd)].cyc);
	end

	exc_check: assert property (@(posedge clk) disable iff (!arst_n)
		exc_valid |-> exc_rd != exc_wr && exc_pc == exc_q[exc_rd].pc
			&& cyc == exc_q[exc_rd].cyc)
	else begin
		err_cnt++;
		$display("mismatch at %0t: exception at pc %h in cycle %0d, expected pc %h in cycle %0d",
			$time, $sampled(exc_pc), $sampled(cyc), exc_q[$sampled(exc_rd)].pc,
			exc_q[$sampled(exc_rd)].cyc);
	end

	quiet_check: assert property (@(posedge clk) disable iff (!arst_n)
		quiet |-> !wb_en && !exc_valid && !fetch_hold)
	else begin
		err_cnt++;
		$display("mismatch at %0t: core outputs active before any instruction was sent", $time);
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////
	function automatic logic [31:0] rand_bits(input int n);
		logic        fb;
		logic [31:0] v;
		v = '0;
		repeat (n) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // Taps 32 22 2 1
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic inst_t r_type(input logic [5:0] fn, input reg_addr_t rd, rs, rt);
		return {op_special, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic inst_t i_type(input logic [5:0] op, input reg_addr_t rt, rs,
	                                 input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Reference behavior of one instruction against the model registers
	function automatic void compute(input inst_t in, output word_t res, output reg_addr_t dst,
	                                output logic wr, output logic trap, output logic is_mul);
		logic [5:0] op;
		logic [5:0] fn;
		word_t      a;
		word_t      b;
		word_t      sx;
		longint     s;
		op     = in[31:26];
		fn     = in[5:0];
		a      = mregs[in[25:21]];
		b      = mregs[in[20:16]];
		sx     = {{16{in[15]}}, in[15:0]};
		res    = '0;
		dst    = in[15:11];
		wr     = 1'b0;
		trap   = 1'b0;
		is_mul = 1'b0;
		if (op == op_special) begin
			wr = 1'b1;
			case (fn)
				fn_add, fn_addu: res = a + b;
				fn_sub:          res = a - b;
				fn_and:          res = a & b;
				fn_or:           res = a | b;
				fn_xor:          res = a ^ b;
				fn_slt:          res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				fn_mul: begin
					res    = word_t'(longint'(a) * longint'(b));
					is_mul = 1'b1;
				end
				default:         wr = 1'b0;
			endcase
			s    = longint'($signed(a)) + longint'($signed(b));
			trap = fn == fn_add && s != longint'($signed(res));
		end else if (op == op_addi) begin
			dst  = in[20:16];
			wr   = 1'b1;
			res  = a + sx;
			s    = longint'($signed(a)) + longint'($signed(sx));
			trap = s != longint'($signed(res)); // Sum does not fit in 32 signed bits
		end else if (op == op_ori) begin
			dst = in[20:16];
			wr  = 1'b1;
			res = a | {16'h0, in[15:0]};
		end else if (op == op_lui) begin
			dst = in[20:16];
			wr  = 1'b1;
			res = {in[15:0], 16'h0};
		end
		if (dst == 5'd0) wr = 1'b0;
	endfunction

	task automatic model_step(input inst_t in, input word_t pc);
		word_t     res;
		reg_addr_t dst;
		logic      wr;
		logic      trap;
		logic      is_mul;
		if (cyc == trap_at + 1) begin // Taken in the same edge as the flush
			mul_pending = 1'b0;
			return;
		end
		compute(in, res, dst, wr, trap, is_mul);
		if (trap) begin
			exc_q[exc_wr] = '{pc: pc, cyc: cyc + 1};
			exc_wr++;
			trap_at = cyc;
		end else if (wr) begin
			mregs[dst]   = res;
			wb_q[wb_wr] = '{addr: dst, data: res, cyc: cyc + (is_mul ? mul_cycles + 2 : 2)};
			wb_wr++;
		end
		mul_pending = is_mul;
	endtask

	task automatic issue(input inst_t in);
		int holds;
		int want;
		holds      = 0;
		want       = mul_pending ? mul_cycles : 0;
		inst_valid = 1'b1;
		inst       = in;
		inst_pc    = pc_next;
		@(negedge clk);
		while (fetch_hold) begin
			holds++;
			@(negedge clk);
		end
		hold_len: assert (holds == want) else begin
			err_cnt++;
			$display("mismatch at %0t: fetch_hold lasted %0d cycles, expected %0d",
				$time, holds, want);
		end
		model_step(in, pc_next);
		pc_next = pc_next + 32'd4;
		@(posedge clk);
		#5;
	endtask

	task automatic gap(input int n);
		inst_valid = 1'b0;
		repeat (n) @(posedge clk);
		#5;
	endtask

	task automatic rand_inst(output inst_t i);
		logic [31:0] sel;
		logic [31:0] v;
		reg_addr_t   rs;
		reg_addr_t   rt;
		reg_addr_t   rd;
		logic [15:0] imm;
		word_t       res;
		reg_addr_t   dst;
		logic        wr;
		logic        trap;
		logic        is_mul;
		sel = rand_bits(4);
		v   = rand_bits(3);
		rs  = {2'b00, v[2:0]};
		v   = rand_bits(3);
		rt  = {2'b00, v[2:0]};
		v   = rand_bits(3);
		rd  = {2'b00, v[2:0]}; // Small register range keeps hazards frequent
		v   = rand_bits(16);
		imm = v[15:0];
		case (sel % 10)
			0:       i = r_type(fn_add, rd, rs, rt);
			1:       i = r_type(fn_addu, rd, rs, rt);
			2:       i = r_type(fn_sub, rd, rs, rt);
			3:       i = r_type(fn_and, rd, rs, rt);
			4:       i = r_type(fn_or, rd, rs, rt);
			5:       i = r_type(fn_xor, rd, rs, rt);
			6:       i = r_type(fn_slt, rd, rs, rt);
			7:       i = i_type(op_addi, rt, rs, imm);
			8:       i = i_type(op_ori, rt, rs, imm);
			default: i = i_type(op_lui, rt, rs, imm);
		endcase
		compute(i, res, dst, wr, trap, is_mul);
		if (trap) i = r_type(fn_xor, rd, rs, rt);
	endtask

	task automatic drain();
		int n;
		n          = 0;
		inst_valid = 1'b0;
		while (n < 80 && (wb_rd != wb_wr || exc_rd != exc_wr || fetch_hold)) begin
			@(posedge clk);
			#5;
			n++;
		end
		drained: assert (wb_rd == wb_wr && exc_rd == exc_wr) else begin
			err_cnt++;
			$display("Expected writebacks or exceptions never appeared at %0t", $time);
		end
		mul_pending = 1'b0;
	endtask

	task automatic end_test(input string name);
		drain();
		tests_run++;
		if (err_cnt != err_before) begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, err_cnt - err_before);
		end else begin
			$display("test %s: passed", name);
		end
		err_before = err_cnt;
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial begin
		inst_t       i;
		logic [31:0] v;
		arst_n       = 1'b0;
		inst_valid   = 1'b0;
		inst         = '0;
		inst_pc      = '0;
		lfsr         = 32'd1;
		err_before   = 0;
		tests_run    = 0;
		tests_failed = 0;
		trap_at      = -10;
		mul_pending  = 1'b0;
		quiet        = 1'b0;
		pc_next      = 32'h0000_1000;
		for (int r = 0; r < 32; r++) mregs[r] = '0;
		repeat (10) @(posedge clk);
		#5;
		arst_n = 1'b1;

		quiet = 1'b1;
		repeat (6) @(posedge clk);
		#5;
		quiet = 1'b0;
		for (int r = 1; r < 8; r++) begin // ORI right after LUI needs the bypass
			v = rand_bits(16);
			issue(i_type(op_lui, reg_addr_t'(r), 5'd0, v[15:0]));
			v = rand_bits(16);
			issue(i_type(op_ori, reg_addr_t'(r), reg_addr_t'(r), v[15:0]));
		end
		end_test("reset_and_first_writebacks");

		repeat (60) begin
			rand_inst(i);
			issue(i);
		end
		end_test("random_alu");

		issue(r_type(fn_addu, 5'd1, 5'd2, 5'd3));
		issue(r_type(fn_sub, 5'd4, 5'd1, 5'd2));
		issue(r_type(fn_xor, 5'd5, 5'd1, 5'd4));
		issue(r_type(fn_or, 5'd6, 5'd5, 5'd1));
		issue(r_type(fn_slt, 5'd7, 5'd4, 5'd5));
		issue(r_type(fn_addu, 5'd2, 5'd7, 5'd6));
		issue(r_type(fn_and, 5'd3, 5'd2, 5'd2));
		end_test("forwarding");

		repeat (40) begin
			v = rand_bits(2);
			if (v[1:0] == 2'd0) begin
				v = rand_bits(2);
				gap(int'(v[1:0]) + 1);
			end
			rand_inst(i);
			issue(i);
		end
		end_test("valid_gaps");

		repeat (4) begin
			issue(r_type(fn_mul, 5'd3, 5'd1, 5'd2));
			issue(r_type(fn_addu, 5'd4, 5'd3, 5'd1)); // Held during the multiply
			issue(r_type(fn_xor, 5'd1, 5'd4, 5'd2));
		end
		end_test("multiply");

		issue(i_type(op_lui, 5'd1, 5'd0, 16'h7fff));
		issue(i_type(op_ori, 5'd1, 5'd1, 16'hffff));
		issue(r_type(fn_add, 5'd2, 5'd1, 5'd1));
		issue(i_type(op_ori, 5'd3, 5'd0, 16'h1111));
		issue(i_type(op_ori, 5'd4, 5'd0, 16'h2222));
		issue(i_type(op_addi, 5'd5, 5'd1, 16'h0001));
		issue(r_type(fn_or, 5'd6, 5'd1, 5'd1));
		issue(r_type(fn_addu, 5'd7, 5'd1, 5'd4));
		end_test("overflow_trap");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (tests_failed == 0 && err_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin
		#(longint'(clk_period) * (planned_insts * 40 + 1000));
		$display("Watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- logic/core_top.sv
module core_top (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               inst_valid,
	input  isa_pkg::inst_t     inst,
	input  isa_pkg::word_t     inst_pc,
	output logic               fetch_hold,
	output logic               wb_en,
	output isa_pkg::reg_addr_t wb_addr,
	output isa_pkg::word_t     wb_data,
	output logic               exc_valid,
	output isa_pkg::word_t     exc_pc
);
	import pipe_pkg::*;

	id_ex_t id_bundle;
	id_ex_t ex_bundle;
	ex_wb_t ex_result;
	ex_wb_t wb;
	stall_t stall;
	logic   flush;
	logic   busy;

	decode_stage u_decode (
		.clk        (clk),
		.arst_n     (arst_n),
		.inst       (inst),
		.inst_pc    (inst_pc),
		.ex_fwd     (ex_result),
		.wb_fwd     (wb),
		.out_bundle (id_bundle)
	);

	id_ex_reg u_id_ex (
		.clk       (clk),
		.arst_n    (arst_n),
		.stall     (stall),
		.flush     (flush),
		.id_bundle (id_bundle),
		.ex_bundle (ex_bundle)
	);

	execute_stage u_execute (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_bundle (ex_bundle),
		.result    (ex_result),
		.busy      (busy),
		.exc_valid (exc_valid),
		.exc_pc    (exc_pc)
	);

	ex_wb_reg u_ex_wb (
		.clk       (clk),
		.arst_n    (arst_n),
		.stall     (stall),
		.flush     (flush),
		.ex_result (ex_result),
		.wb        (wb)
	);

	pipe_ctrl u_ctrl (
		.inst_valid (inst_valid),
		.ex_busy    (busy),
		.exc        (exc_valid),
		.stall      (stall),
		.flush      (flush)
	);

	assign fetch_hold = stall[stall_fetch];
	assign wb_en      = wb.wr_en;
	assign wb_addr    = wb.dest;
	assign wb_data    = wb.data;

endmodule

//--- logic/pipe_ctrl.sv
module pipe_ctrl (
	input  logic             inst_valid,
	input  logic             ex_busy,
	input  logic             exc,
	output pipe_pkg::stall_t stall,
	output logic             flush
);
	import pipe_pkg::*;

	////////////////////////////////
	// Stall priority
	////////////////////////////////
	always_comb begin
		stall = '0;
		if (ex_busy) begin
			stall[stall_fetch] = 1'b1; // Fetch side must keep its instruction
			stall[stall_id]    = 1'b1;
			stall[stall_ex]    = 1'b1;
		end else if (!inst_valid) begin
			stall[stall_id] = 1'b1; // Decode has nothing while execute still drains
		end
	end

	// A trap empties both pipeline registers at the next edge
	assign flush = exc;

endmodule

//--- logic/ex_wb_reg.sv
module ex_wb_reg (
	input  logic             clk,
	input  logic             arst_n,
	input  pipe_pkg::stall_t stall,
	input  logic             flush,
	input  pipe_pkg::ex_wb_t ex_result,
	output pipe_pkg::ex_wb_t wb
);
	import pipe_pkg::*;

	logic ex_run;
	logic wb_run;

	assign ex_run = !stall[stall_ex];
	assign wb_run = !stall[stall_wb];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb <= ex_wb_bubble;
		end else if (flush) begin
			wb <= ex_wb_bubble;
		end else if (!ex_run && wb_run) begin
			wb <= ex_wb_bubble; // Nothing leaves execute while the multiplier runs
		end else if (wb_run) begin
			wb <= ex_result;
		end
	end

endmodule

//--- logic/execute_stage.sv
module execute_stage (
	input  logic             clk,
	input  logic             arst_n,
	input  pipe_pkg::id_ex_t in_bundle,
	output pipe_pkg::ex_wb_t result,
	output logic             busy,
	output logic             exc_valid,
	output isa_pkg::word_t   exc_pc
);
	import isa_pkg::*;

	localparam int cnt_w = $clog2(mul_cycles);

	typedef enum logic [1:0] {
		mul_idle,
		mul_run,
		mul_done
	} mul_state_t;

	mul_state_t       state;
	logic [cnt_w-1:0] cnt;
	word_t            mcand;
	word_t            mplier;
	word_t            acc;
	word_t            sum;
	word_t            alu_out;
	logic             is_mul;
	logic             overflow;

	assign is_mul = in_bundle.alu_op == alu_mul;
	assign busy   = state == mul_run || (state == mul_idle && is_mul);

	////////////////////////////////
	// ALU
	////////////////////////////////
	assign sum = in_bundle.op_a + in_bundle.op_b;

	// Same input signs with a different result sign
	assign overflow = in_bundle.op_a[31] == in_bundle.op_b[31] && sum[31] != in_bundle.op_a[31];

	always_comb begin
		case (in_bundle.alu_op)
			alu_add, alu_addu: alu_out = sum;
			alu_sub:           alu_out = in_bundle.op_a - in_bundle.op_b;
			alu_and:           alu_out = in_bundle.op_a & in_bundle.op_b;
			alu_or:            alu_out = in_bundle.op_a | in_bundle.op_b;
			alu_xor:           alu_out = in_bundle.op_a ^ in_bundle.op_b;
			alu_slt:           alu_out = word_t'($signed(in_bundle.op_a) < $signed(in_bundle.op_b));
			alu_lui:           alu_out = in_bundle.op_b;
			alu_mul:           alu_out = acc;
			default:           alu_out = '0;
		endcase
	end

	assign exc_valid = in_bundle.trap_en && overflow;
	assign exc_pc    = in_bundle.pc;

	assign result.wr_en = in_bundle.wr_en && !busy && !exc_valid;
	assign result.dest  = in_bundle.dest;
	assign result.data  = alu_out;

	////////////////////////////////
	// Multiplier
	////////////////////////////////
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= mul_idle;
			cnt   <= '0;
		end else begin
			case (state)
				mul_idle: if (is_mul) begin
					state <= mul_run;
					cnt   <= cnt_w'(1); // Bit 0 is taken while loading
				end
				mul_run: begin
					cnt <= cnt + 1'b1;
					if (cnt == cnt_w'(mul_cycles - 1)) begin
						state <= mul_done;
					end
				end
				default: state <= mul_idle; // Product sits in acc for one cycle
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == mul_idle && is_mul) begin
			acc    <= in_bundle.op_b[0] ? in_bundle.op_a : '0;
			mcand  <= in_bundle.op_a << 1;
			mplier <= in_bundle.op_b >> 1;
		end else if (state == mul_run) begin
			if (mplier[0]) begin
				acc <= acc + mcand;
			end
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	busy_bounded: assert property (
		@(posedge clk) disable iff (!arst_n)
		$rose(busy) |-> ##[1:mul_cycles] !busy
	) else $error("multiplier busy for more than %0d cycles", mul_cycles);

endmodule

//--- logic/id_ex_reg.sv
module id_ex_reg (
	input  logic             clk,
	input  logic             arst_n,
	input  pipe_pkg::stall_t stall,
	input  logic             flush,
	input  pipe_pkg::id_ex_t id_bundle,
	output pipe_pkg::id_ex_t ex_bundle
);
	import pipe_pkg::*;

	logic id_run;
	logic ex_run;

	assign id_run = !stall[stall_id];
	assign ex_run = !stall[stall_ex];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_bundle <= id_ex_bubble;
		end else if (flush) begin
			ex_bundle <= id_ex_bubble; // Drops the instruction behind a trap
		end else if (!id_run && ex_run) begin
			ex_bundle <= id_ex_bubble;
		end else if (id_run) begin
			ex_bundle <= id_bundle;
		end
	end

	// The bubble after a flush can neither write back nor trap again
	flush_kills_write: assert property (
		@(posedge clk) disable iff (!arst_n)
		flush |=> !ex_bundle.wr_en && !flush
	) else $error("write enable or flush survived a flush");

endmodule

//--- logic/decode_stage.sv
module decode_stage (
	input  logic             clk,
	input  logic             arst_n,
	input  isa_pkg::inst_t   inst,
	input  isa_pkg::word_t   inst_pc,
	input  pipe_pkg::ex_wb_t ex_fwd,
	input  pipe_pkg::ex_wb_t wb_fwd,
	output pipe_pkg::id_ex_t out_bundle
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// Execute holds the younger result, so it is checked first
	function automatic word_t bypass(input reg_addr_t addr, input word_t rf_val,
	                                 input ex_wb_t ex_src, input ex_wb_t wb_src);
		if (ex_src.wr_en && ex_src.dest == addr) begin
			return ex_src.data;
		end
		if (wb_src.wr_en && wb_src.dest == addr) begin
			return wb_src.data;
		end
		return rf_val;
	endfunction

	logic [op_w-1:0]    opcode;
	logic [funct_w-1:0] funct;
	logic [imm_w-1:0]   imm;
	reg_addr_t          rs;
	reg_addr_t          rt;
	reg_addr_t          rd;
	word_t              rf_a;
	word_t              rf_b;
	word_t              imm_val;
	alu_op_t            alu_op;
	reg_addr_t          dest;
	logic               writes;
	logic               use_imm;
	logic               trap_en;
	logic               wr_en;

	assign opcode = inst[31 -: op_w];
	assign rs     = inst[25:21];
	assign rt     = inst[20:16];
	assign rd     = inst[15:11];
	assign funct  = inst[funct_w-1:0];
	assign imm    = inst[imm_w-1:0];

	reg_file u_reg_file (
		.clk       (clk),
		.arst_n    (arst_n),
		.rd_addr_a (rs),
		.rd_addr_b (rt),
		.rd_data_a (rf_a),
		.rd_data_b (rf_b),
		.wr        (wb_fwd)
	);

	always_comb begin
		alu_op  = alu_nop;
		dest    = rd;
		writes  = 1'b0;
		use_imm = 1'b0;
		trap_en = 1'b0;
		imm_val = {{(word_w - imm_w){imm[imm_w-1]}}, imm}; // Sign extended by default
		case (opcode)
			op_special: begin
				writes = 1'b1;
				case (funct)
					fn_add:  begin
						alu_op  = alu_add;
						trap_en = 1'b1;
					end
					fn_addu: alu_op = alu_addu;
					fn_sub:  alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_slt:  alu_op = alu_slt;
					fn_mul:  alu_op = alu_mul;
					default: writes = 1'b0; // Unknown function runs as a NOP
				endcase
			end
			op_addi: begin
				alu_op  = alu_add;
				dest    = rt;
				writes  = 1'b1;
				use_imm = 1'b1;
				trap_en = 1'b1;
			end
			op_ori: begin
				alu_op  = alu_or;
				dest    = rt;
				writes  = 1'b1;
				use_imm = 1'b1;
				imm_val = {{(word_w - imm_w){1'b0}}, imm};
			end
			op_lui: begin
				alu_op  = alu_lui;
				dest    = rt;
				writes  = 1'b1;
				use_imm = 1'b1;
				imm_val = {imm, {(word_w - imm_w){1'b0}}};
			end
			default: ;
		endcase
	end

	assign wr_en = writes && dest != nop_reg;

	assign out_bundle.alu_op  = alu_op;
	assign out_bundle.op_a    = bypass(rs, rf_a, ex_fwd, wb_fwd);
	assign out_bundle.op_b    = use_imm ? imm_val : bypass(rt, rf_b, ex_fwd, wb_fwd);
	assign out_bundle.dest    = wr_en ? dest : nop_reg;
	assign out_bundle.wr_en   = wr_en;
	assign out_bundle.trap_en = trap_en;
	assign out_bundle.inst    = inst;
	assign out_bundle.pc      = inst_pc;

endmodule

//--- logic/reg_file.sv
module reg_file (
	input  logic               clk,
	input  logic               arst_n,
	input  isa_pkg::reg_addr_t rd_addr_a,
	input  isa_pkg::reg_addr_t rd_addr_b,
	output isa_pkg::word_t     rd_data_a,
	output isa_pkg::word_t     rd_data_b,
	input  pipe_pkg::ex_wb_t   wr
);
	import isa_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (wr.wr_en && wr.dest != nop_reg) begin
			regs[wr.dest] <= wr.data;
		end
	end

	assign rd_data_a = (rd_addr_a == nop_reg) ? '0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == nop_reg) ? '0 : regs[rd_addr_b];

	// Decode never lets a write to register 0 travel down the pipe
	wr_not_zero: assert property (
		@(posedge clk) disable iff (!arst_n)
		wr.wr_en |-> wr.dest != nop_reg
	) else $error("write enable reached the register file for register 0");

endmodule

//--- logic/pipe_pkg.sv
package pipe_pkg;

	////////////////////////////////
	// Stall vector
	////////////////////////////////
	typedef logic [3:0] stall_t;

	localparam int stall_fetch = 0;
	localparam int stall_id    = 1;
	localparam int stall_ex    = 2;
	localparam int stall_wb    = 3;

	////////////////////////////////
	// Stage bundles
	////////////////////////////////
	typedef struct packed {
		isa_pkg::alu_op_t   alu_op;
		isa_pkg::word_t     op_a;
		isa_pkg::word_t     op_b;
		isa_pkg::reg_addr_t dest;
		logic               wr_en;
		logic               trap_en; // Signed overflow raises an exception
		isa_pkg::inst_t     inst;
		isa_pkg::word_t     pc;
	} id_ex_t;

	typedef struct packed {
		logic               wr_en;
		isa_pkg::reg_addr_t dest;
		isa_pkg::word_t     data;
	} ex_wb_t;

	// All zero means NOP into register 0 with no write
	localparam id_ex_t id_ex_bubble = '0;
	localparam ex_wb_t ex_wb_bubble = '0;

endpackage

//--- logic/isa_pkg.sv
package isa_pkg;

	////////////////////////////////
	// Field widths
	////////////////////////////////
	localparam int word_w  = 32;
	localparam int reg_w   = 5;
	localparam int op_w    = 6;
	localparam int funct_w = 6;
	localparam int imm_w   = 16;

	typedef logic [word_w-1:0] word_t;
	typedef logic [reg_w-1:0]  reg_addr_t;
	typedef logic [word_w-1:0] inst_t;
	typedef logic [3:0]        alu_op_t;

	// Register 0 is hardwired to zero
	localparam reg_addr_t nop_reg = '0;

	localparam int mul_cycles = 32; // One product bit per clock

	////////////////////////////////
	// Opcodes and function codes
	////////////////////////////////
	localparam logic [op_w-1:0] op_special = 6'h00;
	localparam logic [op_w-1:0] op_addi    = 6'h08;
	localparam logic [op_w-1:0] op_ori     = 6'h0d;
	localparam logic [op_w-1:0] op_lui     = 6'h0f;

	localparam logic [funct_w-1:0] fn_mul  = 6'h18; // Low word of the product into rd
	localparam logic [funct_w-1:0] fn_add  = 6'h20;
	localparam logic [funct_w-1:0] fn_addu = 6'h21;
	localparam logic [funct_w-1:0] fn_sub  = 6'h22;
	localparam logic [funct_w-1:0] fn_and  = 6'h24;
	localparam logic [funct_w-1:0] fn_or   = 6'h25;
	localparam logic [funct_w-1:0] fn_xor  = 6'h26;
	localparam logic [funct_w-1:0] fn_slt  = 6'h2a;

	// ALU operations where zero must stay the NOP
	localparam alu_op_t alu_nop  = 4'd0;
	localparam alu_op_t alu_add  = 4'd1;
	localparam alu_op_t alu_addu = 4'd2;
	localparam alu_op_t alu_sub  = 4'd3;
	localparam alu_op_t alu_and  = 4'd4;
	localparam alu_op_t alu_or   = 4'd5;
	localparam alu_op_t alu_xor  = 4'd6;
	localparam alu_op_t alu_slt  = 4'd7;
	localparam alu_op_t alu_mul  = 4'd8;
	localparam alu_op_t alu_lui  = 4'd9;

endpackage
